/* dir_cache_sys.f */
+incdir+common
common/cache_pkg.sv
backing_mem/backing_mem.sv
cache/cache_store.sv
cache/cache_ctrl.sv
hdl/dir_cache_sys.sv
testbench/tb_clock.sv
testbench/tb_dir_cache_sys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f dir_cache_sys.f \
  --top-module tb_dir_cache_sys -o sim_dir_cache_sys

out=$(./obj_dir/sim_dir_cache_sys)
echo "$out"
echo "$out" | grep -q "PASS: all tests"

/* testbench/tb_dir_cache_sys.sv */
`timescale 1ns/100ps

`include "cache_cfg.svh"

module tb_dir_cache_sys
  import cache_pkg::*;
();

  localparam int line_bytes = 4 * `CACHE_LINE_WORDS;
  localparam int tag_span = line_bytes * `CACHE_NUM_SETS;  // bytes covered by one tag
  localparam int model_words = 4 * `CACHE_NUM_SETS * `CACHE_LINE_WORDS;
  localparam int random_ops = 200;
  localparam int directed_ops = 14;
  localparam int timeout_cycles = (random_ops + directed_ops) * 16 + 200;

  logic  clk;
  logic  reset;
  logic  req_valid;
  word_t addr;
  logic  rd;
  logic  wr;
  word_t wdata;
  logic  ready;
  word_t rdata;
  logic  hit;

  // reference model over 4 tags and all sets
  word_t model_mem [model_words];
  tag_t  model_tag [`CACHE_NUM_SETS];
  logic  model_valid [`CACHE_NUM_SETS];

  int word_errors;
  int hit_errors;
  int other_errors;
  int cycle_count;

  tb_clock u_tb_clock (
    .clk (clk)
  );

  dir_cache_sys u_dir_cache_sys (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .addr      (addr),
    .rd        (rd),
    .wr        (wr),
    .wdata     (wdata),
    .ready     (ready),
    .rdata     (rdata),
    .hit       (hit)
  );

  function automatic int unsigned set_of(input word_t a);
    return (a / line_bytes) % `CACHE_NUM_SETS;
  endfunction

  function automatic tag_t tag_of(input word_t a);
    return tag_t'(a / tag_span);
  endfunction

  function automatic word_t make_addr(input int unsigned t, input int unsigned s,
                                      input int unsigned w);
    return word_t'(t * tag_span + s * line_bytes + w * 4);
  endfunction

  task automatic clear_model();
    for (int i = 0; i < model_words; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
      word_errors++;
    end
  endtask

  task automatic check_hit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected hit %0b, actual hit %0b", name, expected, actual);
      hit_errors++;
    end
  endtask

  task automatic check_ready_low(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (ready !== 1'b0) begin
        $display("ERROR %s: ready went high with no request pending", name);
        other_errors++;
      end
    end
  endtask

  task automatic apply_reset(input int cycles);
    @(posedge clk);
    reset <= 1'b1;
    repeat (cycles) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one request held until ready with the response sampled mid-cycle
  task automatic access(input logic is_wr, input word_t a, input word_t d,
                        output word_t data_out, output logic hit_out);
    @(posedge clk);
    req_valid <= 1'b1;
    rd <= !is_wr;
    wr <= is_wr;
    addr <= a;
    wdata <= d;
    forever begin
      @(negedge clk);
      if (ready === 1'b1) break;
    end
    data_out = rdata;
    hit_out = hit;
    @(posedge clk);
    req_valid <= 1'b0;  // dropped on the edge that completes it
    rd <= 1'b0;
    wr <= 1'b0;
  endtask

  // access plus model update and checks
  task automatic do_op(input string name, input logic is_wr, input word_t a, input word_t d);
    word_t       got_data;
    logic        got_hit;
    int unsigned s;
    int unsigned w;
    logic        exp_hit;

    s = set_of(a);
    w = (a / 4) % model_words;
    exp_hit = model_valid[s] && (model_tag[s] == tag_of(a));
    access(is_wr, a, d, got_data, got_hit);
    check_hit(name, exp_hit, got_hit);
    if (!is_wr) begin
      check_word(name, model_mem[w], got_data);
    end else begin
      model_mem[w] = d;
    end
    model_valid[s] = 1'b1;  // allocate on any miss
    model_tag[s] = tag_of(a);
  endtask

  task automatic test_reset_state();
    check_ready_low("reset_state", 4);
    do_op("first_read", 1'b0, make_addr(1, 2, 1), '0);
  endtask

  task automatic test_read_hit();
    do_op("read_again", 1'b0, make_addr(1, 2, 1), '0);
    do_op("read_neighbor", 1'b0, make_addr(1, 2, 2), '0);
  endtask

  task automatic test_write_hit();
    do_op("write_hit", 1'b1, make_addr(1, 2, 2), 32'hdead_beef);
    do_op("read_written", 1'b0, make_addr(1, 2, 2), '0);
    do_op("neighbor_low", 1'b0, make_addr(1, 2, 0), '0);
    do_op("neighbor_high", 1'b0, make_addr(1, 2, 3), '0);
  endtask

  task automatic test_eviction();
    do_op("evict_write_a", 1'b1, make_addr(0, 3, 1), 32'ha5a5_1234);
    do_op("evict_access_b", 1'b0, make_addr(2, 3, 1), '0);  // dirty victim goes out
    do_op("evict_reread_a", 1'b0, make_addr(0, 3, 1), '0);
  endtask

  task automatic test_random();
    int unsigned t;
    int unsigned s;
    int unsigned w;
    logic        is_wr;

    for (int i = 0; i < random_ops; i++) begin
      t = $urandom % 4;
      s = $urandom % `CACHE_NUM_SETS;
      w = $urandom % `CACHE_LINE_WORDS;
      is_wr = 1'($urandom % 2);
      do_op("random", is_wr, make_addr(t, s, w), $urandom);
    end
  endtask

  task automatic test_reset_midrun();
    do_op("midrun_write", 1'b1, make_addr(2, 10, 2), 32'h1357_9bdf);
    do_op("midrun_hit", 1'b0, make_addr(2, 10, 2), '0);
    do_op("midrun_evict", 1'b0, make_addr(3, 10, 2), '0);  // written line lands in memory
    apply_reset(5);
    clear_model();  // memory is cleared along with the cache
    check_ready_low("midrun_reset", 4);
    do_op("after_reset", 1'b0, make_addr(2, 10, 2), '0);
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: no completion after %0d cycles", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int unsigned seed_val;

    seed_val = $urandom(75);
    reset = 1'b1;
    req_valid = 1'b0;
    addr = '0;
    rd = 1'b0;
    wr = 1'b0;
    wdata = '0;
    word_errors = 0;
    hit_errors = 0;
    other_errors = 0;
    cycle_count = 0;
    clear_model();

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    test_reset_state();
    test_read_hit();
    test_write_hit();
    test_eviction();
    test_random();
    test_reset_midrun();

    $display("errors: word %0d, hit %0d, other %0d", word_errors, hit_errors, other_errors);
    if (word_errors + hit_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;  // 4 ns period

endmodule

/* hdl/dir_cache_sys.sv */
`timescale 1ns/100ps

module dir_cache_sys
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  req_valid,
  input  word_t addr,
  input  logic  rd,
  input  logic  wr,
  input  word_t wdata,
  output logic  ready,
  output word_t rdata,
  output logic  hit
);

  // controller <-> line store
  logic  lookup_hit;
  logic  victim_dirty;
  tag_t  victim_tag;
  line_t victim_line;
  logic  write_word;
  logic  fill_line;

  // controller <-> backing memory
  mem_cmd_e mem_cmd;
  word_t    mem_line_addr;
  line_t    mem_wline;
  line_t    mem_rline;
  logic     mem_done;

  cache_ctrl u_cache_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .rd            (rd),
    .wr            (wr),
    .addr          (addr),
    .lookup_hit    (lookup_hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_line   (victim_line),
    .mem_done      (mem_done),
    .ready         (ready),
    .hit           (hit),
    .write_word    (write_word),
    .fill_line     (fill_line),
    .mem_cmd       (mem_cmd),
    .mem_line_addr (mem_line_addr),
    .mem_wline     (mem_wline)
  );

  cache_store u_cache_store (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .wdata        (wdata),
    .write_word   (write_word),
    .fill_line    (fill_line),
    .fill_data    (mem_rline),   // refill straight from memory
    .lookup_hit   (lookup_hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .rd_word      (rdata)
  );

  backing_mem u_backing_mem (
    .clk           (clk),
    .reset         (reset),
    .mem_cmd       (mem_cmd),
    .mem_line_addr (mem_line_addr),
    .mem_wline     (mem_wline),
    .mem_rline     (mem_rline),
    .mem_done      (mem_done)
  );

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  logic     rd,
  input  logic     wr,
  input  word_t    addr,
  input  logic     lookup_hit,
  input  logic     victim_dirty,
  input  tag_t     victim_tag,
  input  line_t    victim_line,
  input  logic     mem_done,
  output logic     ready,
  output logic     hit,
  output logic     write_word,
  output logic     fill_line,
  output mem_cmd_e mem_cmd,
  output word_t    mem_line_addr,
  output line_t    mem_wline
);

  cache_state_e state;
  cache_state_e next_state;
  logic         missed;  // first lookup of this request missed
  index_t       index;
  word_t        req_line_addr;
  word_t        victim_line_addr;

  assign index = addr[offset_bits +: index_bits];

  // line aligned byte addresses for refill and write-back
  assign req_line_addr = {addr[31:offset_bits], {offset_bits{1'b0}}};
  assign victim_line_addr = {victim_tag, index, {offset_bits{1'b0}}};

  // a request completes only in compare_tag once the line is present
  assign ready = (state == st_compare_tag) && lookup_hit;
  assign hit = ready && !missed;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      missed <= 1'b0;
    end else begin
      state <= next_state;
      if (state == st_idle) begin
        missed <= 1'b0;  // fresh request
      end else if (state == st_compare_tag && !lookup_hit) begin
        missed <= 1'b1;
      end
    end
  end

  always_comb begin
    next_state = state;
    write_word = 1'b0;
    fill_line = 1'b0;
    mem_cmd = mem_none;
    mem_line_addr = '0;
    mem_wline = '0;

    case (state)
      st_idle: begin
        if (req_valid && (rd || wr)) begin
          next_state = st_compare_tag;
        end
      end

      st_compare_tag: begin
        if (lookup_hit) begin
          write_word = wr;  // write hit merges the word, marks dirty
          next_state = st_idle;
        end else if (victim_dirty) begin
          // push the old line out first
          mem_cmd = mem_write;
          mem_line_addr = victim_line_addr;
          mem_wline = victim_line;
          next_state = st_writeback;
        end else begin
          mem_cmd = mem_read;
          mem_line_addr = req_line_addr;
          next_state = st_allocate;
        end
      end

      st_writeback: begin
        if (mem_done) begin
          // memory is free again on the done cycle
          mem_cmd = mem_read;
          mem_line_addr = req_line_addr;
          next_state = st_allocate;
        end
      end

      st_allocate: begin
        if (mem_done) begin
          fill_line = 1'b1;  // mem_rline is valid with done
          next_state = st_compare_tag;
        end
      end

      default: begin
        next_state = st_idle;
      end
    endcase
  end

endmodule

/* cache/cache_store.sv */
`timescale 1ns/100ps

`include "cache_cfg.svh"

module cache_store
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t addr,
  input  word_t wdata,
  input  logic  write_word,
  input  logic  fill_line,
  input  line_t fill_data,
  output logic  lookup_hit,
  output logic  victim_dirty,
  output tag_t  victim_tag,
  output line_t victim_line,
  output word_t rd_word
);

  tag_t  tag_arr  [`CACHE_NUM_SETS];
  line_t data_arr [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid;
  logic [`CACHE_NUM_SETS-1:0] dirty;

  logic [word_sel_bits-1:0] word_sel;
  index_t index;
  tag_t   tag;

  // address fields, byte bits ignored
  assign word_sel = addr[byte_bits +: word_sel_bits];
  assign index = addr[offset_bits +: index_bits];
  assign tag = addr[31 -: tag_bits];

  assign lookup_hit = valid[index] && (tag_arr[index] == tag);
  assign victim_dirty = valid[index] && dirty[index];
  assign victim_tag = tag_arr[index];
  assign victim_line = data_arr[index];
  assign rd_word = data_arr[index][32*word_sel +: 32];

  // line state bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (fill_line) begin
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;  // fresh copy of memory
    end else if (write_word) begin
      dirty[index] <= 1'b1;
    end
  end

  // tag and data arrays, fill wins over a word write
  always_ff @(posedge clk) begin
    if (fill_line) begin
      data_arr[index] <= fill_data;
      tag_arr[index] <= tag;
    end else if (write_word) begin
      data_arr[index][32*word_sel +: 32] <= wdata;
    end
  end

endmodule

/* backing_mem/backing_mem.sv */
`timescale 1ns/100ps

`include "cache_cfg.svh"

module backing_mem
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  mem_cmd_e mem_cmd,
  input  word_t    mem_line_addr,
  input  line_t    mem_wline,
  output line_t    mem_rline,
  output logic     mem_done
);

  localparam int mem_addr_bits = $clog2(`CACHE_MEM_LINES);
  localparam int cnt_bits = $clog2(`CACHE_MEM_LATENCY);

  line_t mem [`CACHE_MEM_LINES];

  logic                     busy;
  logic [cnt_bits-1:0]      cnt;      // cycles left before done
  mem_cmd_e                 op;
  logic [mem_addr_bits-1:0] op_addr;
  line_t                    op_wline;

  // latch the command, new ones are dropped while busy
  always_ff @(posedge clk) begin
    if (!busy && mem_cmd != mem_none) begin
      op <= mem_cmd;
      op_addr <= mem_line_addr[offset_bits +: mem_addr_bits];  // line number, low bits
      op_wline <= mem_wline;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      cnt <= '0;
      mem_done <= 1'b0;
      mem_rline <= '0;
      for (int i = 0; i < `CACHE_MEM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else begin
      mem_done <= 1'b0;
      if (!busy && mem_cmd != mem_none) begin
        busy <= 1'b1;
        cnt <= cnt_bits'(`CACHE_MEM_LATENCY - 2);
      end else if (busy) begin
        if (cnt == '0) begin
          busy <= 1'b0;
          mem_done <= 1'b1;  // high in the latency-th cycle after the command
          if (op == mem_write) begin
            mem[op_addr] <= op_wline;
          end else begin
            mem_rline <= mem[op_addr];
          end
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

  `include "cache_cfg.svh"

  // byte address split: tag | index | word select | byte
  localparam int byte_bits = 2;
  localparam int word_sel_bits = $clog2(`CACHE_LINE_WORDS);
  localparam int offset_bits = byte_bits + word_sel_bits;
  localparam int index_bits = $clog2(`CACHE_NUM_SETS);
  localparam int tag_bits = 32 - index_bits - offset_bits;

  typedef logic [31:0] word_t;
  typedef logic [`CACHE_LINE_WORDS*32-1:0] line_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;

  typedef enum logic [1:0] {
    st_idle,
    st_compare_tag,
    st_writeback,
    st_allocate
  } cache_state_e;

  typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_cmd_e;

endpackage

/* common/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// words per cache line
`define CACHE_LINE_WORDS 4

// direct mapped, one line per set
`define CACHE_NUM_SETS 16

// backing memory depth in lines
`define CACHE_MEM_LINES 256

`define CACHE_MEM_LATENCY 3  // command to done, at least 2

`endif
